// File: source/motion_pkg.sv
package motion_pkg;

  // Axis and ring sizing
  localparam int NUM_AXES   = 3;
  localparam int MOVE_SLOTS = 4;  // Slots per axis ring
  localparam int SLOT_BITS  = 2;  // log2 of MOVE_SLOTS
  localparam int AXIS_BITS  = 2;  // Wide enough for NUM_AXES

  // Move length in ticks
  typedef logic [31:0] duration_t;

  // Signed rate and rate increment
  typedef logic signed [31:0] rate_t;

  // Signed substep accumulator
  typedef logic signed [31:0] accum_t;

  // Clock cycles per tick, minus one
  typedef logic [7:0] divisor_t;

  typedef logic [SLOT_BITS-1:0] slot_t;  // Slot within a ring
  typedef logic [AXIS_BITS-1:0] axis_t;  // Axis number

  // Move memory address, axis in the upper bits
  typedef logic [AXIS_BITS+SLOT_BITS-1:0] addr_t;

  // Taken off the accumulator on every step
  // Just under max positive, leaves headroom for the rate
  localparam accum_t STEP_ROLLBACK = 32'h7fffff9b;

  // Per axis DDA states
  typedef enum logic [1:0] {
    IDLE,      // Waiting for a pending slot
    FETCH,     // Requesting the memory port
    WAIT_RSP,  // Granted, record on its way
    RUN        // Ticking through the move
  } axis_state_t;

endpackage

// File: source/move_queue.sv
`timescale 1ns/100ps

module move_queue
  import motion_pkg::*;
(
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic                                 halt,
  input  logic                                 cmd_valid,
  output logic                                 cmd_ready,
  input  axis_t                                cmd_axis,
  input  duration_t                            cmd_duration,
  input  rate_t                                cmd_rate,
  input  rate_t                                cmd_accel,
  input  logic [NUM_AXES-1:0][MOVE_SLOTS-1:0] stepfinished,
  output logic [NUM_AXES-1:0][MOVE_SLOTS-1:0] stepready,
  output slot_t [NUM_AXES-1:0]                 write_ind,
  output logic                                 wr_en,
  output addr_t                                wr_addr,
  output duration_t                            wr_duration,
  output rate_t                                wr_rate,
  output rate_t                                wr_accel
);

  slot_t sel_ind;   // Write cursor of the addressed axis
  logic  sel_full;  // Slot under the cursor still owned by the axis
  logic  axis_ok;   // Axis number in range
  logic  accept;

  // Pick the ring the command targets
  always_comb begin
    sel_ind  = '0;
    sel_full = 1'b0;
    axis_ok  = 1'b0;
    for (int a = 0; a < NUM_AXES; a++) begin
      if (cmd_axis == axis_t'(a)) begin
        axis_ok  = 1'b1;
        sel_ind  = write_ind[a];
        sel_full = stepready[a][write_ind[a]] ^ stepfinished[a][write_ind[a]];
      end
    end
  end

  assign cmd_ready = !halt && !sel_full;  // Hold off host on full ring or halt
  assign accept    = cmd_valid && cmd_ready;

  // Bad axis numbers are consumed and dropped
  assign wr_en       = accept && axis_ok;
  assign wr_addr     = {cmd_axis, sel_ind};
  assign wr_duration = cmd_duration;
  assign wr_rate     = cmd_rate;
  assign wr_accel    = cmd_accel;

  // Ready toggle marks the slot as pending for the axis
  always_ff @(posedge CLK) begin
    if (resetn) begin
      stepready <= '0;
      write_ind <= '0;
    end else if (wr_en) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        if (cmd_axis == axis_t'(a)) begin
          stepready[a][sel_ind] <= ~stepready[a][sel_ind];
          write_ind[a]          <= sel_ind + 1'b1;  // Wraps around the ring
        end
      end
    end
  end

endmodule

// File: source/move_buffer.sv
`timescale 1ns/100ps

module move_buffer
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      wr_en,
  input  addr_t     wr_addr,
  input  duration_t wr_duration,
  input  rate_t     wr_rate,
  input  rate_t     wr_accel,
  input  logic      rd_en,
  input  addr_t     rd_addr,
  output duration_t rd_duration,
  output rate_t     rd_rate,
  output rate_t     rd_accel
);

  // One entry per slot of every axis ring
  duration_t dur_mem   [NUM_AXES*MOVE_SLOTS];
  rate_t     rate_mem  [NUM_AXES*MOVE_SLOTS];
  rate_t     accel_mem [NUM_AXES*MOVE_SLOTS];

  // Host side write
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      dur_mem[wr_addr]   <= wr_duration;
      rate_mem[wr_addr]  <= wr_rate;
      accel_mem[wr_addr] <= wr_accel;
    end
  end

  // Registered read, data valid the cycle after rd_en
  // Old data wins on a same address collision
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      rd_duration <= dur_mem[rd_addr];
      rd_rate     <= rate_mem[rd_addr];
      rd_accel    <= accel_mem[rd_addr];
    end
  end

endmodule

// File: source/move_arbiter.sv
`timescale 1ns/100ps

module move_arbiter
  import motion_pkg::*;
(
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic [NUM_AXES-1:0]   req_valid,
  output logic [NUM_AXES-1:0]   req_ready,
  input  addr_t [NUM_AXES-1:0]  req_addr,
  output logic                  rd_en,
  output addr_t                 rd_addr,
  output logic [NUM_AXES-1:0]   rsp_valid
);

  axis_t last_gnt;  // Most recent winner
  axis_t gnt_idx;   // Winner this cycle
  logic  found;     // Any request granted

  // Search starts one past the last winner
  always_comb begin
    int c;
    found   = 1'b0;
    gnt_idx = '0;
    for (int k = 1; k <= NUM_AXES; k++) begin
      c = (int'(last_gnt) + k) % NUM_AXES;
      if (!found && req_valid[c]) begin
        found   = 1'b1;
        gnt_idx = axis_t'(c);
      end
    end
  end

  // One hot grant back to the axes
  always_comb begin
    req_ready = '0;
    if (found)
      req_ready[gnt_idx] = 1'b1;
  end

  assign rd_en   = found;              // Memory read only on a grant
  assign rd_addr = req_addr[gnt_idx];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      last_gnt  <= axis_t'(NUM_AXES - 1);  // Axis 0 goes first
      rsp_valid <= '0;
    end else begin
      // Read data lands next cycle, steer valid to the owner
      rsp_valid <= req_ready;
      if (found)
        last_gnt <= gnt_idx;
    end
  end

endmodule

// File: source/dda_axis.sv
`timescale 1ns/100ps

module dda_axis
  import motion_pkg::*;
#(
  parameter int AXIS = 0  // Axis number, upper bits of the fetch address
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  halt,
  input  divisor_t              clock_divisor,
  input  logic [MOVE_SLOTS-1:0] stepready,
  input  slot_t                 write_ind,
  output logic [MOVE_SLOTS-1:0] stepfinished,
  output logic                  req_valid,
  input  logic                  req_ready,
  output addr_t                 req_addr,
  input  logic                  rsp_valid,
  input  duration_t             rsp_duration,
  input  rate_t                 rsp_rate,
  input  rate_t                 rsp_accel,
  output logic                  step,
  output logic                  move_done
);

  axis_state_t state;
  slot_t       read_ind;  // Slot being fetched or run
  duration_t   tickdown;  // Ticks left, zero on the last one
  divisor_t    clkcnt;    // Cycles left to the next tick
  accum_t      accum;     // Substep accumulator
  rate_t       rate_r;    // Current rate
  rate_t       accel_r;   // Rate increment per tick
  accum_t      acc_next;
  logic        pending;
  logic        tick;
  logic        load;      // Record arriving this cycle
  logic        last_tick;

  // Ready and finished differ while the slot holds an unrun move
  assign pending   = stepready[read_ind] ^ stepfinished[read_ind];
  assign tick      = (state == RUN) && (clkcnt == '0);
  assign last_tick = tick && (tickdown == '0);
  assign load      = (state == WAIT_RSP) && rsp_valid;
  assign acc_next  = accum + rate_r;

  assign req_valid = (state == FETCH);
  assign req_addr  = {axis_t'(AXIS), read_ind};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state        <= IDLE;
      read_ind     <= '0;
      stepfinished <= '0;
      accum        <= '0;
      rate_r       <= '0;
      step         <= 1'b0;
      move_done    <= 1'b0;
    end else begin
      step      <= 1'b0;  // Single cycle pulses
      move_done <= 1'b0;
      if (halt) begin
        // Flush everything queued, accumulator survives
        stepfinished <= stepready;
        read_ind     <= write_ind;
        state        <= IDLE;
      end else begin
        case (state)
          IDLE: begin
            if (pending)
              state <= FETCH;
          end
          FETCH: begin
            if (req_ready)
              state <= WAIT_RSP;
          end
          WAIT_RSP: begin
            if (rsp_valid) begin
              state  <= RUN;
              rate_r <= rsp_rate;
            end
          end
          RUN: begin
            if (tick) begin
              rate_r <= rate_r + accel_r;
              // Positive after the add means a step, roll back now
              if (acc_next > 0) begin
                accum <= acc_next - STEP_ROLLBACK;
                step  <= 1'b1;
              end else begin
                accum <= acc_next;
              end
            end
            if (last_tick) begin
              stepfinished[read_ind] <= ~stepfinished[read_ind];  // Hand slot back
              read_ind               <= read_ind + 1'b1;
              move_done              <= 1'b1;
              state                  <= IDLE;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Move payload and tick timing, loaded before every use
  always_ff @(posedge CLK) begin
    if (load) begin
      tickdown <= rsp_duration;
      accel_r  <= rsp_accel;
      clkcnt   <= clock_divisor;  // First tick after divisor+1 cycles
    end else if (state == RUN) begin
      if (tick) begin
        clkcnt   <= clock_divisor;
        tickdown <= tickdown - 1'b1;
      end else begin
        clkcnt <= clkcnt - 1'b1;
      end
    end
  end

endmodule

// File: source/motion_top.sv
`timescale 1ns/100ps

module motion_top
  import motion_pkg::*;
(
  input  logic                CLK,
  input  logic                resetn,
  input  logic                halt,
  input  divisor_t            clock_divisor,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  axis_t               cmd_axis,
  input  duration_t           cmd_duration,
  input  rate_t               cmd_rate,
  input  rate_t               cmd_accel,
  output logic [NUM_AXES-1:0] step,
  output logic [NUM_AXES-1:0] move_done
);

  // Slot ownership between queue and axes
  logic [NUM_AXES-1:0][MOVE_SLOTS-1:0] stepready;
  logic [NUM_AXES-1:0][MOVE_SLOTS-1:0] stepfinished;
  slot_t [NUM_AXES-1:0]                write_ind;

  // Memory write side
  logic      wr_en;
  addr_t     wr_addr;
  duration_t wr_duration;
  rate_t     wr_rate;
  rate_t     wr_accel;

  // Memory read side, data shared by all axes
  logic      rd_en;
  addr_t     rd_addr;
  duration_t rd_duration;
  rate_t     rd_rate;
  rate_t     rd_accel;

  // Fetch handshake
  logic [NUM_AXES-1:0]  req_valid;
  logic [NUM_AXES-1:0]  req_ready;
  addr_t [NUM_AXES-1:0] req_addr;
  logic [NUM_AXES-1:0]  rsp_valid;

  move_queue u_queue (
    .CLK          (CLK),
    .resetn       (resetn),
    .halt         (halt),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_axis     (cmd_axis),
    .cmd_duration (cmd_duration),
    .cmd_rate     (cmd_rate),
    .cmd_accel    (cmd_accel),
    .stepfinished (stepfinished),
    .stepready    (stepready),
    .write_ind    (write_ind),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_duration  (wr_duration),
    .wr_rate      (wr_rate),
    .wr_accel     (wr_accel)
  );

  move_buffer u_buffer (
    .CLK         (CLK),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_duration (wr_duration),
    .wr_rate     (wr_rate),
    .wr_accel    (wr_accel),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_duration (rd_duration),
    .rd_rate     (rd_rate),
    .rd_accel    (rd_accel)
  );

  move_arbiter u_arbiter (
    .CLK       (CLK),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rsp_valid (rsp_valid)
  );

  // One DDA engine per axis
  for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
    dda_axis #(
      .AXIS (i)
    ) u_axis (
      .CLK           (CLK),
      .resetn        (resetn),
      .halt          (halt),
      .clock_divisor (clock_divisor),
      .stepready     (stepready[i]),
      .write_ind     (write_ind[i]),
      .stepfinished  (stepfinished[i]),
      .req_valid     (req_valid[i]),
      .req_ready     (req_ready[i]),
      .req_addr      (req_addr[i]),
      .rsp_valid     (rsp_valid[i]),
      .rsp_duration  (rd_duration),
      .rsp_rate      (rd_rate),
      .rsp_accel     (rd_accel),
      .step          (step[i]),
      .move_done     (move_done[i])
    );
  end

endmodule

// File: bench/motion_tb.sv
`timescale 1ns/100ps

module motion_tb
  import motion_pkg::*;
();

  localparam int WAIT_LIMIT  = 5000;  // Cycles before any wait gives up
  localparam int REC_DEPTH   = 64;    // Model records per axis
  localparam int FLUSH_MOVES = 3;     // Long moves per axis discarded by halt

  logic                CLK;
  logic                resetn;
  logic                halt;
  divisor_t            clock_divisor;
  logic                cmd_valid;
  logic                cmd_ready;
  axis_t               cmd_axis;
  duration_t           cmd_duration;
  rate_t               cmd_rate;
  rate_t               cmd_accel;
  logic [NUM_AXES-1:0] step;
  logic [NUM_AXES-1:0] move_done;

  // Queued moves per axis, head is the next one to finish
  duration_t   rec_dur     [NUM_AXES][REC_DEPTH];
  rate_t       rec_rate    [NUM_AXES][REC_DEPTH];
  rate_t       rec_accel   [NUM_AXES][REC_DEPTH];
  int          head        [NUM_AXES];
  int          tail        [NUM_AXES];
  int          expect_done [NUM_AXES];  // Moves the DUT has to finish
  int          completed   [NUM_AXES];
  int          step_cnt    [NUM_AXES];  // Steps since last move_done
  accum_t      model_acc   [NUM_AXES];  // Carried across moves
  logic [31:0] rng;
  logic        full_seen;               // Ring back-pressure observed

  motion_top dut (
    .CLK           (CLK),
    .resetn        (resetn),
    .halt          (halt),
    .clock_divisor (clock_divisor),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_axis      (cmd_axis),
    .cmd_duration  (cmd_duration),
    .cmd_rate      (cmd_rate),
    .cmd_accel     (cmd_accel),
    .step          (step),
    .move_done     (move_done)
  );

  always #4 CLK = ~CLK;  // 8 ns period

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic report_error(input string what);
    $display("error: %s", what);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // DDA model, duration plus one ticks, updates the axis accumulator
  function automatic int expected_steps(input int a, input duration_t dur,
                                        input rate_t rate0, input rate_t accel);
    accum_t acc;
    accum_t nxt;
    rate_t  rate;
    int     steps;
    acc   = model_acc[a];
    rate  = rate0;
    steps = 0;
    for (int t = 0; t <= int'(dur); t++) begin
      nxt  = acc + rate;
      rate = rate + accel;
      if (nxt > 0) begin
        steps++;
        acc = nxt - STEP_ROLLBACK;  // Rollback in the step cycle
      end else begin
        acc = nxt;
      end
    end
    model_acc[a] = acc;
    return steps;
  endfunction

  // Pulses stay one cycle wide, host held off during halt
  assert property (@(posedge CLK) disable iff (resetn) (step & $past(step)) == '0)
    else report_error("step pulse wider than one cycle");
  assert property (@(posedge CLK) disable iff (resetn) (move_done & $past(move_done)) == '0)
    else report_error("move_done pulse wider than one cycle");
  assert property (@(posedge CLK) disable iff (resetn) halt |-> !cmd_ready)
    else report_error("cmd_ready high while halt is asserted");

  // Count steps, score each move at its move_done
  always @(negedge CLK) begin : monitor
    int exp_steps;
    if (!resetn) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        if (halt) begin  // Pending moves are discarded
          head[a]     = tail[a];
          step_cnt[a] = 0;
        end
        if (step[a])
          step_cnt[a]++;
        if (move_done[a]) begin
          if (head[a] == tail[a])
            report_error($sformatf("move_done on axis %0d with no move queued", a));
          exp_steps = expected_steps(a, rec_dur[a][head[a]], rec_rate[a][head[a]],
                                     rec_accel[a][head[a]]);
          assert (step_cnt[a] == exp_steps)
            else report_mismatch($sformatf("step_count[%0d]", a), step_cnt[a], exp_steps);
          head[a]++;
          completed[a]++;
          step_cnt[a] = 0;
        end
      end
    end
  end

  // Hold the command until accepted, then log it for the model
  task automatic push_move(input int a, input duration_t dur, input rate_t rate,
                           input rate_t accel);
    int waited;
    waited       = 0;
    cmd_valid    = 1'b1;
    cmd_axis     = axis_t'(a);
    cmd_duration = dur;
    cmd_rate     = rate;
    cmd_accel    = accel;
    @(negedge CLK);
    while (!cmd_ready) begin
      if (!halt)
        full_seen = 1'b1;
      waited++;
      if (waited > WAIT_LIMIT)
        report_error("command never accepted, cmd_ready stayed low");
      @(negedge CLK);
    end
    @(posedge CLK);  // Transfer edge
    #1;
    cmd_valid = 1'b0;
    if (tail[a] >= REC_DEPTH)
      report_error("too many moves for the model record store");
    rec_dur[a][tail[a]]   = dur;
    rec_rate[a][tail[a]]  = rate;
    rec_accel[a][tail[a]] = accel;
    tail[a]++;
    expect_done[a]++;
  endtask

  task automatic wait_drain();
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int a = 0; a < NUM_AXES; a++)
        if (head[a] != tail[a])
          busy = 1'b1;
      if (busy) begin
        waited++;
        if (waited > WAIT_LIMIT)
          report_error("queued moves did not complete in time");
        @(posedge CLK);
        #1;
      end
    end
  endtask

  task automatic check_done_counts();
    for (int a = 0; a < NUM_AXES; a++) begin
      assert (completed[a] == expect_done[a])
        else report_mismatch($sformatf("move_done_count[%0d]", a), completed[a],
                             expect_done[a]);
      assert (step_cnt[a] == 0)  // No steps outside a move
        else report_mismatch($sformatf("idle_step_count[%0d]", a), step_cnt[a], 0);
    end
  endtask

  initial begin : stimulus
    int        ax;
    duration_t dur;
    rate_t     rate;
    rate_t     accel;
    CLK           = 1'b0;
    resetn        = 1'b1;
    halt          = 1'b0;
    clock_divisor = 8'd1;  // Tick every 2 cycles
    cmd_valid     = 1'b0;
    cmd_axis      = '0;
    cmd_duration  = '0;
    cmd_rate      = '0;
    cmd_accel     = '0;
    rng           = 32'h698f;
    full_seen     = 1'b0;
    for (int a = 0; a < NUM_AXES; a++) begin
      head[a]        = 0;
      tail[a]        = 0;
      expect_done[a] = 0;
      completed[a]   = 0;
      step_cnt[a]    = 0;
      model_acc[a]   = '0;
    end
    repeat (8) @(posedge CLK);
    #1 resetn = 1'b0;

    // Quiet outputs, host port open
    @(negedge CLK);
    assert (step == '0) else report_mismatch("step", step, 0);
    assert (move_done == '0) else report_mismatch("move_done", move_done, 0);
    assert (cmd_ready) else report_mismatch("cmd_ready", cmd_ready, 1);
    @(posedge CLK);
    #1;

    push_move(0, 32'd20, 32'h18000000, 32'h0);  // Constant rate
    wait_drain();
    check_done_counts();
    push_move(1, 32'd30, 32'h04000000, 32'h00800000);  // Accelerating
    wait_drain();
    check_done_counts();

    // Random mix on all axes through the arbiter
    for (int n = 0; n < 12; n++) begin
      rng   = xorshift(rng);
      ax    = int'(rng % NUM_AXES);
      rng   = xorshift(rng);
      dur   = 32'd4 + (rng % 24);
      rng   = xorshift(rng);
      rate  = 32'h02000000 + (rng & 32'h0fffffff);
      rng   = xorshift(rng);
      accel = rate_t'(rng & 32'h001fffff) - rate_t'(32'h00100000);
      push_move(ax, dur, rate, accel);
    end
    wait_drain();
    check_done_counts();

    // Overfill one ring
    full_seen = 1'b0;
    for (int n = 0; n < MOVE_SLOTS + 2; n++)
      push_move(2, 32'd30, 32'h0c000000 + n * 32'h00400000, 32'h00040000);
    assert (full_seen) else report_error("cmd_ready never dropped on a full ring");
    wait_drain();
    check_done_counts();

    // Zero rate moves keep the accumulator, then flush them
    for (int a = 0; a < NUM_AXES; a++)
      for (int k = 0; k < FLUSH_MOVES; k++)
        push_move(a, 32'd200, 32'h0, 32'h0);
    repeat (20) @(posedge CLK);
    #1 halt = 1'b1;
    @(posedge CLK);
    #1 halt = 1'b0;
    for (int a = 0; a < NUM_AXES; a++)
      expect_done[a] = expect_done[a] - FLUSH_MOVES;  // Whole batch still queued
    @(negedge CLK);
    assert (cmd_ready) else report_mismatch("cmd_ready", cmd_ready, 1);
    repeat (600) @(negedge CLK);  // Flushed moves must stay silent
    @(posedge CLK);
    #1;
    push_move(0, 32'd25, 32'h1c000000, 32'h00100000);
    wait_drain();
    check_done_counts();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog.f
source/motion_pkg.sv
source/move_queue.sv
source/move_buffer.sv
source/move_arbiter.sv
source/dda_axis.sv
source/motion_top.sv
bench/motion_tb.sv

// File: Bender.yml
package:
  name: motion_ctrl

sources:
  - source/motion_pkg.sv
  - source/move_queue.sv
  - source/move_buffer.sv
  - source/move_arbiter.sv
  - source/dda_axis.sv
  - source/motion_top.sv
  - target: test
    files:
      - bench/motion_tb.sv
